//--- test/fpsu_lane_stimulus.txt
# num op ord a b sel_a sel_b inv_mask bus_a bus_b exp_data exp_flags exp_excpt
# all hex except num; sel = {now[3:0], late[3:0]}; flags = {lt, eq, unord}
1 0 0 0123456789abcdef ff00ff00f0f0f0f0 00 00 0 0 0 0100450080a0c0e0 0 0
2 1 0 0123456789abcdef ff00ff00f0f0f0f0 00 00 0 0 0 ff23ff67f9fbfdff 0 0
3 2 0 0123456789abcdef ff00ff00f0f0f0f0 00 00 0 0 0 fe23ba67795b3d1f 0 0
4 3 0 0123456789abcdef ff00ff00f0f0f0f0 00 00 0 0 0 00230067090b0d0f 0 0
5 4 0 3f80000040000000 0000000000000000 00 00 0 0 0 400000003f800000 0 0
6 5 0 1111111122222222 0000000000000000 00 00 0 0 0 2222222222222222 0 0
7 6 0 aaaaaaaabbbbbbbb ccccccccdddddddd 00 00 0 0 0 aaaaaaaadddddddd 0 0
8 0 0 ffffffffffffffff ffffffff00000000 40 00 0 deadbeefcafef00d 0 deadbeef00000000 0 0
9 1 0 1111000011110000 ffffffffffffffff 00 02 0 0 0000123400005678 1111123411115678 0 0
10 2 0 0 0 08 10 0 0f0f0f0f0f0f0f0f 00000000ffffffff 0f0f0f0ff0f0f0f0 0 0
11 8 0 3f800000c0000000 40000000bf800000 00 00 0 0 0 ffffffffffffffff 0 0
12 8 0 404000003f800000 40000000bf800000 00 00 0 0 0 0000000000000000 0 0
13 9 0 800000007fc00000 000000007fc00000 00 00 0 0 0 ffffffff00000000 0 0
14 8 0 7f80000100000000 3f8000003f800000 00 00 0 0 0 00000000ffffffff 0 0
15 7 1 000000003f800000 7fc0000040000000 00 00 0 0 0 0000000000000000 4 0
16 0 0 ffff0000ffff0000 0f0f0f0f0f0f0f0f 00 00 0 0 0 0f0f00000f0f0000 4 0
17 7 1 000000007fc00000 000000003f800000 00 00 0 0 0 0000000000000000 1 1
18 7 0 000000007fc00000 000000003f800000 00 00 0 0 0 0000000000000000 1 0
19 7 1 0000000080000000 0000000000000000 00 00 0 0 0 0000000000000000 2 0
20 7 1 000000007f800001 0000000000000000 00 00 1 0 0 0000000000000000 1 0
21 1 0 0000000000000000 0000000000000001 00 00 1 0 0 0000000000000001 1 0
22 9 1 7fc0000040000000 7fc0000040000000 00 00 0 0 0 00000000ffffffff 1 1
23 5 0 123456789abcdef0 0000000000000000 00 00 0 0 0 9abcdef09abcdef0 1 0
24 7 0 bf80000040000000 3f8000003f800000 00 00 0 0 0 0000000000000000 0 0

//--- fpsu_lane.f
src/fpsu_data_pkg.sv
src/fpsu_op_pkg.sv
src/fwd_operand_sel.sv
src/fpsu_op_decode.sv
src/fpsu_bitwise.sv
src/fpsu_compare.sv
src/fpsu_result_stage.sv
src/fpsu_lane.sv
test/fpsu_lane_tb.sv

//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --top-module fpsu_lane_tb -f fpsu_lane.f -o fpsu_lane_sim \
  && ./obj_dir/fpsu_lane_sim 2>&1 | tee sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

//--- test/fpsu_lane_tb.sv
`timescale 1ns/10ps

module fpsu_lane_tb;
  import fpsu_data_pkg::*;
  import fpsu_op_pkg::*;

  localparam int num_fwd = 4;

  logic        clk;
  logic        rst;
  issue_t      issue;
  fp_csr_t     csr;
  operand_t    fwd_bus [num_fwd];
  result_t     result;
  cmp_flags_t  flags;
  logic        excpt;
  logic [63:0] vec [64][13];  // one row per stimulus line with the file's columns
  int          nvec = 0;
  int          pipe [2] = '{-1, -1};  // rows in flight where -1 marks an idle slot
  logic        mask_pend = 1'b0;  // invalid mask of the last issued row
  logic [31:0] lfsr = 32'h88e9_c74d;
  int          passed = 0;
  int          failed = 0;
  int          errors = 0;
  int          cycles = 0;
  int          limit = 0;

  fpsu_lane #(.num_fwd(num_fwd)) fpsu_lane_inst (
    .clk     (clk),
    .rst     (rst),
    .issue   (issue),
    .csr     (csr),
    .fwd_bus (fwd_bus),
    .result  (result),
    .flags   (flags),
    .excpt   (excpt)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // selected buses carry the line's operand, the rest get noise
  task automatic drive_buses(input logic [3:0] hit_a, input logic [3:0] hit_b, input int row);
    for (int j = 0; j < num_fwd; j++) begin
      if (hit_a[j]) begin
        fwd_bus[j].raw = vec[row][8];
      end else if (hit_b[j]) begin
        fwd_bus[j].raw = vec[row][9];
      end else begin
        for (int k = 0; k < 64; k++) begin
          fwd_bus[j].raw[k] = lfsr[0];
          lfsr = lfsr_next(lfsr);
        end
      end
    end
  endtask

  // outputs seen now belong to the operation driven two falling edges back
  task automatic step(input int nxt);
    int   r;
    logic bad;
    @(negedge clk);
    csr.inv_mask = mask_pend;  // result stage gates excpt one cycle after issue
    r       = pipe[1];
    pipe[1] = pipe[0];
    pipe[0] = nxt;
    bad     = 1'b0;
    if (r < 0) begin
      if (result.valid || excpt) begin
        $display("result.valid or excpt high with no operation in flight");
        errors++;
      end
    end else begin
      if (!result.valid) begin
        $display("test %0d: no result.valid two cycles after issue", vec[r][0]);
        bad = 1'b1;
      end
      if (result.data.raw !== vec[r][10]) begin
        $display("Fail test %0d: result.data = %h, expected %h",
                 vec[r][0], result.data.raw, vec[r][10]);
        bad = 1'b1;
      end
      if (flags !== vec[r][11][2:0]) begin
        $display("Fail test %0d: flags = %h, expected %h", vec[r][0], flags, vec[r][11][2:0]);
        bad = 1'b1;
      end
      if (excpt !== vec[r][12][0]) begin
        $display("Fail test %0d: excpt = %h, expected %h", vec[r][0], excpt, vec[r][12][0]);
        bad = 1'b1;
      end
      if (bad) begin
        $display("test %0d failed", vec[r][0]);
        failed++;
      end else begin
        $display("test %0d passed", vec[r][0]);
        passed++;
      end
    end
  endtask

  initial begin
    int    fd;
    string line;
    rst   = 1'b1;
    issue = '0;
    csr   = '0;
    for (int j = 0; j < num_fwd; j++) begin
      fwd_bus[j] = '0;
    end
    fd = $fopen("test/fpsu_lane_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open test/fpsu_lane_stimulus.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0 && nvec < 64) begin
        if (line.len() > 1 && line[0] != "#") begin
          if ($sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h",
                      vec[nvec][0], vec[nvec][1], vec[nvec][2], vec[nvec][3], vec[nvec][4],
                      vec[nvec][5], vec[nvec][6], vec[nvec][7], vec[nvec][8], vec[nvec][9],
                      vec[nvec][10], vec[nvec][11], vec[nvec][12]) == 13) begin
            nvec++;
          end else begin
            $display("stimulus line could not be read: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
    if (nvec == 0) begin
      $display("no stimulus lines were read");
      errors++;
    end
    limit = 2 * (nvec + 2 + 3) + 20;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < nvec; i++) begin
      if ((|vec[i][5][3:0]) || (|vec[i][6][3:0])) begin
        step(-1);  // late select needs the bus value one cycle early
        issue = '0;
        drive_buses(vec[i][5][3:0], vec[i][6][3:0], i);
      end
      step(i);
      issue.en     = 1'b1;
      issue.opcode = fpsu_opcode_e'(vec[i][1][3:0]);
      issue.ord    = vec[i][2][0];
      issue.a.raw  = vec[i][3];
      issue.b.raw  = vec[i][4];
      issue.sel_a  = vec[i][5][7:0];
      issue.sel_b  = vec[i][6][7:0];
      mask_pend    = vec[i][7][0];
      drive_buses(vec[i][5][7:4], vec[i][6][7:4], i);
    end
    repeat (3) begin
      step(-1);
      issue = '0;
    end
    $display("tests passed: %0d, tests failed: %0d, other errors: %0d", passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    while (limit == 0 || cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- src/fpsu_lane.sv
`timescale 1ns/10ps

module fpsu_lane #(
  parameter int num_fwd = 4
) (
  input  logic                      clk,
  input  logic                      rst,
  input  fpsu_op_pkg::issue_t       issue,
  input  fpsu_data_pkg::fp_csr_t    csr,
  input  fpsu_data_pkg::operand_t   fwd_bus [num_fwd],
  output fpsu_data_pkg::result_t    result,
  output fpsu_data_pkg::cmp_flags_t flags,
  output logic                      excpt
);
  import fpsu_data_pkg::*;
  import fpsu_op_pkg::*;

  operand_t   opnd_a;
  operand_t   opnd_b;
  fpsu_ctrl_t ctrl;
  operand_t   bit_res;
  operand_t   pmask_res;
  cmp_flags_t cmp_flags;
  logic       invalid;

  fwd_operand_sel #(.num_fwd(num_fwd)) opnd_a_sel (
    .clk     (clk),
    .rst     (rst),
    .reg_val (issue.a),
    .sel     (issue.sel_a),
    .fwd_bus (fwd_bus),
    .opnd    (opnd_a)
  );

  fwd_operand_sel #(.num_fwd(num_fwd)) opnd_b_sel (
    .clk     (clk),
    .rst     (rst),
    .reg_val (issue.b),
    .sel     (issue.sel_b),
    .fwd_bus (fwd_bus),
    .opnd    (opnd_b)
  );

  fpsu_op_decode decode (
    .clk   (clk),
    .rst   (rst),
    .issue (issue),
    .ctrl  (ctrl)
  );

  fpsu_bitwise bitwise (
    .ctrl (ctrl),
    .a    (opnd_a),
    .b    (opnd_b),
    .res  (bit_res)
  );

  fpsu_compare compare (
    .ctrl    (ctrl),
    .a       (opnd_a),
    .b       (opnd_b),
    .pmask   (pmask_res),
    .flags   (cmp_flags),
    .invalid (invalid)
  );

  fpsu_result_stage result_stage (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl),
    .csr       (csr),
    .bit_res   (bit_res),
    .pmask     (pmask_res),
    .cmp_flags (cmp_flags),
    .invalid   (invalid),
    .result    (result),
    .flags     (flags),
    .excpt     (excpt)
  );

endmodule

//--- src/fpsu_result_stage.sv
`timescale 1ns/10ps

module fpsu_result_stage (
  input  logic                      clk,
  input  logic                      rst,
  input  fpsu_op_pkg::fpsu_ctrl_t   ctrl,
  input  fpsu_data_pkg::fp_csr_t    csr,
  input  fpsu_data_pkg::operand_t   bit_res,
  input  fpsu_data_pkg::operand_t   pmask,
  input  fpsu_data_pkg::cmp_flags_t cmp_flags,
  input  logic                      invalid,
  output fpsu_data_pkg::result_t    result,
  output fpsu_data_pkg::cmp_flags_t flags,
  output logic                      excpt
);
  import fpsu_data_pkg::*;
  import fpsu_op_pkg::*;

  operand_t sel_data;
  operand_t data_q;
  logic     valid_q;

  always_comb begin
    case (ctrl.unit)
      unit_bitwise: sel_data = bit_res;
      unit_pmask:   sel_data = pmask;
      default:      sel_data = '0;  // scalar compare returns only flags
    endcase
  end

  always_ff @(posedge clk) begin
    data_q <= sel_data;
    if (rst) begin
      valid_q <= 1'b0;
      flags   <= '0;
      excpt   <= 1'b0;
    end else begin
      valid_q <= ctrl.valid;
      excpt   <= invalid && !csr.inv_mask;
      if (ctrl.valid && ctrl.scalar) begin
        flags <= cmp_flags;  // held until the next scalar compare
      end
    end
  end

  assign result = {valid_q, data_q};

  // invalid comes from the compare, valid from decode; they must line up
  assert property (@(posedge clk) disable iff (rst) excpt |-> result.valid)
    else $error("excpt raised without result.valid");

endmodule

//--- src/fpsu_compare.sv
`timescale 1ns/10ps

module fpsu_compare (
  input  fpsu_op_pkg::fpsu_ctrl_t   ctrl,
  input  fpsu_data_pkg::operand_t   a,
  input  fpsu_data_pkg::operand_t   b,
  output fpsu_data_pkg::operand_t   pmask,
  output fpsu_data_pkg::cmp_flags_t flags,
  output logic                      invalid
);
  import fpsu_data_pkg::*;

  function automatic logic is_nan(input sng_t x);
    return (&x.exp) && (|x.frac);
  endfunction

  // sign and magnitude ordering of one single lane
  function automatic cmp_flags_t sng_cmp(input sng_t x, input sng_t y);
    logic [sng_width-2:0] mx;
    logic [sng_width-2:0] my;
    cmp_flags_t           f;
    mx = {x.exp, x.frac};
    my = {y.exp, y.frac};
    f  = '0;
    if (is_nan(x) || is_nan(y)) begin
      f.unord = 1'b1;
    end else if (mx == '0 && my == '0) begin
      f.eq = 1'b1;  // +0 equals -0
    end else if (x.sign != y.sign) begin
      f.lt = x.sign;
    end else begin
      f.eq = (mx == my);
      f.lt = x.sign ? (mx > my) : (mx < my);
    end
    return f;
  endfunction

  cmp_flags_t hi_f;
  cmp_flags_t lo_f;
  logic       hi_hit;
  logic       lo_hit;
  logic       nan_hi;
  logic       nan_lo;

  always_comb begin
    hi_f      = sng_cmp(a.sp.hi, b.sp.hi);
    lo_f      = sng_cmp(a.sp.lo, b.sp.lo);
    hi_hit    = ctrl.pkd_eq ? hi_f.eq : hi_f.lt;
    lo_hit    = ctrl.pkd_eq ? lo_f.eq : lo_f.lt;
    pmask.raw = {{sng_width{hi_hit}}, {sng_width{lo_hit}}};
    flags     = lo_f;  // scalar compare looks at lo lanes only
    nan_hi    = is_nan(a.sp.hi) || is_nan(b.sp.hi);
    nan_lo    = is_nan(a.sp.lo) || is_nan(b.sp.lo);
    invalid   = ctrl.valid && ctrl.ord && (nan_lo || (nan_hi && !ctrl.scalar));
    if (ctrl.valid) begin
      assert ($onehot0(hi_f) && $onehot0(lo_f))
        else $error("compare flags overlap: hi=%b lo=%b", hi_f, lo_f);
    end
  end

endmodule

//--- src/fpsu_bitwise.sv
`timescale 1ns/10ps

module fpsu_bitwise (
  input  fpsu_op_pkg::fpsu_ctrl_t ctrl,
  input  fpsu_data_pkg::operand_t a,
  input  fpsu_data_pkg::operand_t b,
  output fpsu_data_pkg::operand_t res
);
  import fpsu_op_pkg::*;

  always_comb begin
    res = a;
    case (ctrl.perm)
      perm_swap: begin
        res.sp.hi = a.sp.lo;
        res.sp.lo = a.sp.hi;
      end
      perm_dupl: begin
        res.sp.hi = a.sp.lo;
        res.sp.lo = a.sp.lo;
      end
      perm_copya: begin
        res.sp.hi = a.sp.hi;  // keep A high single, merge B low
        res.sp.lo = b.sp.lo;
      end
      default: begin
        case (ctrl.fn)
          fn_and: begin
            res.raw = a.raw & b.raw;
          end
          fn_or: begin
            res.raw = a.raw | b.raw;
          end
          fn_xor: begin
            res.raw = a.raw ^ b.raw;
          end
          default: begin
            res.raw = a.raw & ~b.raw;
          end
        endcase
      end
    endcase
  end

endmodule

//--- src/fpsu_op_decode.sv
`timescale 1ns/10ps

module fpsu_op_decode (
  input  logic                    clk,
  input  logic                    rst,
  input  fpsu_op_pkg::issue_t     issue,
  output fpsu_op_pkg::fpsu_ctrl_t ctrl
);
  import fpsu_op_pkg::*;

  fpsu_ctrl_t dec;

  always_comb begin
    dec       = '0;
    dec.valid = issue.en;
    dec.unit  = unit_bitwise;
    dec.fn    = fn_and;
    dec.perm  = perm_none;
    case (issue.opcode)
      op_and: begin
        dec.fn = fn_and;
      end
      op_or: begin
        dec.fn = fn_or;
      end
      op_xor: begin
        dec.fn = fn_xor;
      end
      op_andn: begin
        dec.fn = fn_andn;
      end
      op_swap: begin
        dec.perm = perm_swap;
      end
      op_dupl: begin
        dec.perm = perm_dupl;
      end
      op_copya: begin
        dec.perm = perm_copya;
      end
      op_cmps: begin
        dec.unit   = unit_flags;
        dec.scalar = 1'b1;
        dec.ord    = issue.ord;
      end
      op_pcmplt: begin
        dec.unit = unit_pmask;
        dec.ord  = issue.ord;
      end
      op_pcmpeq: begin
        dec.unit   = unit_pmask;
        dec.pkd_eq = 1'b1;
        dec.ord    = issue.ord;
      end
      default: begin
        dec.fn = fn_and;  // spare codes run as and
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl <= '0;
    end else begin
      ctrl <= dec;
    end
  end

endmodule

//--- src/fwd_operand_sel.sv
`timescale 1ns/10ps

module fwd_operand_sel #(
  parameter int num_fwd = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  fpsu_data_pkg::operand_t reg_val,
  input  fpsu_op_pkg::fwd_sel_t   sel,
  input  fpsu_data_pkg::operand_t fwd_bus [num_fwd],
  output fpsu_data_pkg::operand_t opnd
);
  import fpsu_data_pkg::*;

  operand_t bus_q [num_fwd];  // bus values from the previous edge
  operand_t pick;

  always_comb begin
    pick = reg_val;
    for (int i = 0; i < num_fwd; i++) begin
      if (sel.late[i]) begin
        pick = bus_q[i];
      end
    end
    for (int i = 0; i < num_fwd; i++) begin
      if (sel.now[i]) begin
        pick = fwd_bus[i];  // current bus beats the late copy
      end
    end
  end

  always_ff @(posedge clk) begin
    bus_q <= fwd_bus;
    opnd  <= pick;
  end

  // issuer must name a single source, current or late, never both
  assert property (@(posedge clk) disable iff (rst)
    $onehot0(sel.now) && $onehot0(sel.late) && !((|sel.now) && (|sel.late)))
    else $error("fwd select not one-hot: now=%h late=%h", sel.now, sel.late);

endmodule

//--- src/fpsu_op_pkg.sv
package fpsu_op_pkg;

  localparam int fwd_w = 4;  // one select bit per forward bus

  typedef enum logic [3:0] {
    op_and    = 4'h0,
    op_or     = 4'h1,
    op_xor    = 4'h2,
    op_andn   = 4'h3,
    op_swap   = 4'h4,
    op_dupl   = 4'h5,
    op_copya  = 4'h6,
    op_cmps   = 4'h7,
    op_pcmplt = 4'h8,
    op_pcmpeq = 4'h9
  } fpsu_opcode_e;

  typedef struct packed {
    logic [fwd_w-1:0] now;   // bus value in the issue cycle
    logic [fwd_w-1:0] late;  // bus value one cycle before issue
  } fwd_sel_t;

  typedef struct packed {
    logic                    en;
    fpsu_opcode_e            opcode;
    logic                    ord;
    fpsu_data_pkg::operand_t a;
    fpsu_data_pkg::operand_t b;
    fwd_sel_t                sel_a;
    fwd_sel_t                sel_b;
  } issue_t;

  typedef enum logic [1:0] {
    unit_bitwise = 2'd0,
    unit_pmask   = 2'd1,
    unit_flags   = 2'd2
  } unit_e;

  typedef enum logic [1:0] {fn_and, fn_or, fn_xor, fn_andn} logic_fn_e;

  typedef enum logic [1:0] {perm_none, perm_swap, perm_dupl, perm_copya} perm_e;

  typedef struct packed {
    logic      valid;
    unit_e     unit;
    logic_fn_e fn;
    perm_e     perm;
    logic      pkd_eq;  // packed compare tests eq instead of lt
    logic      ord;
    logic      scalar;
  } fpsu_ctrl_t;

endpackage

//--- src/fpsu_data_pkg.sv
package fpsu_data_pkg;

  localparam int op_width   = 64;
  localparam int sng_width  = 32;
  localparam int exp_width  = 8;
  localparam int frac_width = 23;

  typedef struct packed {
    logic                  sign;
    logic [exp_width-1:0]  exp;
    logic [frac_width-1:0] frac;
  } sng_t;

  typedef struct packed {
    sng_t hi;
    sng_t lo;
  } sng_pair_t;

  // the same 64-bit word seen as raw bits or as two packed singles
  typedef union packed {
    logic [op_width-1:0] raw;
    sng_pair_t           sp;
  } operand_t;

  typedef struct packed {
    logic lt;
    logic eq;
    logic unord;
  } cmp_flags_t;

  typedef struct packed {
    logic [19:0] rsvd_hi;
    logic        inv_mask;  // set = invalid exception masked
    logic [10:0] rsvd_lo;
  } fp_csr_t;

  typedef struct packed {
    logic     valid;
    operand_t data;
  } result_t;

endpackage
